// File: Makefile
# Verilator build and run of the backup save testbench
VERILATOR ?= verilator
TOP       ?= save_tb
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// File: bench/save_asserts.sv
/* Backup save protocol checks */
`default_nettype none

module save_asserts (
	input wire                     clk_sys,
	input wire                     arst_n,
	input wire                     sd_rd,
	input wire                     sd_wr,
	input wire                     pending,
	input wire                     busy,
	input wire save_pkg::mem_req_t mem
);

	// Block device sees a read or a write, never both
	a_strobe_excl: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr are high in the same cycle");

	// One request per word, low again in the next cycle
	a_req_pulse: assert property (@(posedge clk_sys) disable iff (!arst_n)
		mem.req |=> !mem.req)
		else $error("memory request held longer than one cycle");

	// Flag is cleared at transfer start and stays low until busy drops
	a_pending_idle: assert property (@(posedge clk_sys) disable iff (!arst_n)
		busy |-> !pending)
		else $error("pending is high during a transfer");

endmodule

bind save_top save_asserts u_asserts (
	.clk_sys (clk_sys),
	.arst_n  (arst_n),
	.sd_rd   (sd_rd),
	.sd_wr   (sd_wr),
	.pending (pending),
	.busy    (busy),
	.mem     (mem)
);

`default_nettype wire

// File: bench/save_stim.txt
// cmd_a_b_exp0_exp1_text : cart a=pad b=words exp0=flash_1m exp1=last_addr text=9 bytes
// bus a=kind{eeprom,sram,flash} exp0=pending, mount a=blocks b=readonly, load/save exp0=blocks
05_00_00_0000_0000_000000000000000000
04_00_00_0000_0000_000000000000000000
01_00_08_0001_000E_464C415348314D5F56
02_01_00_0001_0000_000000000000000000
05_00_00_0100_0000_000000000000000000
05_00_00_0000_0000_000000000000000000
01_01_08_0001_000E_464C415348314D5F56
01_00_06_0000_000A_464C415348314D5F58
02_04_00_0001_0000_000000000000000000
05_00_00_0010_0000_000000000000000000
02_01_00_0001_0000_000000000000000000
05_00_00_0080_0000_000000000000000000
04_00_00_0001_0000_000000000000000000
03_14_01_0000_0000_000000000000000000
02_04_00_0001_0000_000000000000000000
05_00_00_0080_0000_000000000000000000
03_08_00_0000_0000_000000000000000000
02_01_00_0001_0000_000000000000000000
05_00_00_0008_0000_000000000000000000
00_00_00_0000_0000_000000000000000000

// File: bench/save_tb.sv
/* Backup save testbench */
`default_nettype none

module save_tb;
	import loader_pkg::*;
	import save_pkg::*;

	localparam int BLOCK_AW     = 8;
	localparam int LBA_W        = 8;
	localparam int WORDS        = 1 << BLOCK_AW; // 16 bit words per block
	localparam int BLOCKS       = 1 << LBA_W;    // A load reads all of them
	localparam int START_LIMIT  = 20;            // Cycles until busy must rise
	localparam int XFER_LIMIT   = 1000000;       // Cycles for one whole transfer
	localparam int QUIET_CYCLES = 30;
	localparam int NREC         = 32;

	// Record commands
	localparam logic [7:0] CMD_END   = 8'h00;
	localparam logic [7:0] CMD_CART  = 8'h01;
	localparam logic [7:0] CMD_BUS   = 8'h02;
	localparam logic [7:0] CMD_MOUNT = 8'h03;
	localparam logic [7:0] CMD_LOAD  = 8'h04;
	localparam logic [7:0] CMD_SAVE  = 8'h05;

	// Event log kinds, entry is {kind, block, word}
	localparam logic [3:0] EV_RD   = 4'h1;
	localparam logic [3:0] EV_WR   = 4'h2;
	localparam logic [3:0] EV_MEMW = 4'h3;
	localparam logic [3:0] EV_MEMR = 4'h4;

	logic                 clk_sys;
	logic                 arst_n;
	dl_stream_t           dl;
	logic                 flash_1m;
	logic [DL_ADDR_W-1:0] last_addr;
	logic                 bus_req;
	save_kind_t           kind;
	logic                 img_mounted;
	logic                 img_readonly;
	logic [LBA_W-1:0]     img_blocks;
	logic                 load_req;
	logic                 save_req;
	logic                 sd_ack;
	logic                 sd_rd;
	logic                 sd_wr;
	logic [LBA_W-1:0]     sd_lba;
	logic                 pending;
	logic                 busy;
	logic                 loading;
	mem_req_t             mem;
	logic                 mem_ack;
	logic                 led;

	integer       seed = 58;
	logic [19:0]  xfer_log [$];       // Device and memory events in order
	logic [127:0] stim [0:NREC-1];

	save_top #(.BLOCK_AW(BLOCK_AW), .LBA_W(LBA_W)) uut (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.dl           (dl),
		.flash_1m     (flash_1m),
		.last_addr    (last_addr),
		.bus_req      (bus_req),
		.kind         (kind),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_blocks   (img_blocks),
		.load_req     (load_req),
		.save_req     (save_req),
		.sd_ack       (sd_ack),
		.sd_rd        (sd_rd),
		.sd_wr        (sd_wr),
		.sd_lba       (sd_lba),
		.pending      (pending),
		.busy         (busy),
		.loading      (loading),
		.mem          (mem),
		.mem_ack      (mem_ack),
		.led          (led)
	);

	initial begin
		clk_sys = 1'b0;
		forever #10 clk_sys = ~clk_sys;
	end

	// ======================================================================
	// Block device and memory models
	// ======================================================================
	initial begin : sd_model
		int delay;
		int hold;
		sd_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			if (sd_rd || sd_wr) begin
				xfer_log.push_back({sd_rd ? EV_RD : EV_WR, sd_lba, 8'h00});
				delay = $random(seed) & 3;
				hold  = 1 + ($random(seed) & 1); // Ack lasts one or two cycles
				repeat (delay) @(negedge clk_sys);
				sd_ack = 1'b1;
				repeat (hold) @(negedge clk_sys);
				sd_ack = 1'b0;
			end
		end
	end

	initial begin : mem_model
		int delay;
		mem_ack = 1'b0;
		forever begin
			@(negedge clk_sys);
			mem_ack = 1'b0; // Ack is a single cycle pulse
			if (mem.req) begin
				xfer_log.push_back({mem.write ? EV_MEMW : EV_MEMR,
					mem.addr.blk, mem.addr.word});
				delay = $random(seed) & 3; // Back-pressure of 0 to 3 cycles
				repeat (delay) @(negedge clk_sys);
				mem_ack = 1'b1;
			end
		end
	end

	// ======================================================================
	// Failure reporting
	// ======================================================================
	task automatic stop_run();
		$display("RESULT: FAIL");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic fail_value(input string name, input logic [31:0] got,
		input logic [31:0] want);
		$display("error t=%0t %s: got 0x%0h expected 0x%0h", $time, name, got, want);
		stop_run();
	endtask

	task automatic fail_text(input string msg);
		$display("t=%0t %s", $time, msg);
		stop_run();
	endtask

	// ======================================================================
	// Stimulus helpers
	// ======================================================================
	task automatic wait_busy(input logic level, input int limit, input string what);
		int n;
		n = 0;
		while (busy !== level) begin
			assert (n < limit) else fail_text({"timeout waiting for ", what});
			@(negedge clk_sys);
			n++;
		end
	endtask

	// Byte i of the download, the string sits after pad filler bytes
	function automatic logic [7:0] byte_at(input int pad, input logic [71:0] text,
		input int i);
		if (i < pad || i >= pad + 9)
			return 8'h2E; // Filler '.'
		return text[8 * (8 - (i - pad)) +: 8]; // First char in the top byte
	endfunction

	task automatic run_download(input int pad, input int len, input logic [71:0] text);
		int k;
		dl.index    = 8'h01; // Neither bios nor code, so a cart
		dl.download = 1'b1;
		for (k = 0; k < len; k++) begin
			dl.addr = DL_ADDR_W'(2 * k);
			dl.data = {byte_at(pad, text, 2 * k + 1), byte_at(pad, text, 2 * k)};
			dl.wr   = 1'b1; // First word lands together with the download rise
			@(negedge clk_sys);
			dl.wr = 1'b0;
			@(negedge clk_sys);
		end
		dl.download = 1'b0; // addr still holds the last word
		dl.index    = '0;
	endtask

	task automatic pulse_request(input logic is_save);
		if (is_save)
			save_req = 1'b1;
		else
			load_req = 1'b1;
		repeat (2) @(negedge clk_sys);
		save_req = 1'b0;
		load_req = 1'b0;
	endtask

	// Nothing may start within the window
	task automatic expect_quiet(input string what);
		repeat (QUIET_CYCLES) begin
			@(negedge clk_sys);
			assert (!busy) else fail_text({what, " started a transfer"});
		end
		assert (xfer_log.size() == 0)
			else fail_value("transfer event count", 32'(xfer_log.size()), 32'd0);
	endtask

	task automatic check_event(inout int idx, input logic [19:0] want);
		assert (xfer_log[idx] == want)
			else fail_value($sformatf("transfer event %0d", idx), 32'(xfer_log[idx]),
				32'(want));
		idx++;
	endtask

	// Load is read then fill per block, save is drain then write
	task automatic check_log(input logic is_load, input int nblk);
		int idx;
		int b;
		int w;
		logic [3:0] mem_ev;
		assert (xfer_log.size() == nblk * (WORDS + 1))
			else fail_value("transfer event count", 32'(xfer_log.size()),
				32'(nblk * (WORDS + 1)));
		idx    = 0;
		mem_ev = is_load ? EV_MEMW : EV_MEMR;
		for (b = 0; b < nblk; b++) begin
			if (is_load)
				check_event(idx, {EV_RD, 8'(b), 8'h00});
			for (w = 0; w < WORDS; w++)
				check_event(idx, {mem_ev, 8'(b), 8'(w)});
			if (!is_load)
				check_event(idx, {EV_WR, 8'(b), 8'h00});
		end
	endtask

	// ======================================================================
	// Record loop
	// ======================================================================
	initial begin : main
		int         r;
		logic       done;
		logic [7:0] cmd;
		logic [7:0] fa;
		logic [7:0] fb;
		logic [15:0] exp0;
		logic [15:0] exp1;
		logic [71:0] text;
		arst_n       = 1'b0;
		dl           = '0;
		bus_req      = 1'b0;
		kind         = '0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_blocks   = '0;
		load_req     = 1'b0;
		save_req     = 1'b0;
		$readmemh("bench/save_stim.txt", stim);
		repeat (10) @(negedge clk_sys);
		arst_n = 1'b1;
		@(negedge clk_sys);
		r    = 0;
		done = 1'b0;
		while (!done) begin
			{cmd, fa, fb, exp0, exp1, text} = stim[r];
			xfer_log.delete();
			case (cmd)
				CMD_END: done = 1'b1;
				CMD_CART: begin
					run_download(int'(fa), int'(fb), text);
					wait_busy(1'b1, START_LIMIT, "load after cart download");
					assert (loading) else fail_value("loading", 32'(loading), 32'd1);
					assert (flash_1m == exp0[0])
						else fail_value("flash_1m", 32'(flash_1m), 32'(exp0[0]));
					assert (last_addr == DL_ADDR_W'(exp1))
						else fail_value("last_addr", 32'(last_addr), 32'(exp1));
					wait_busy(1'b0, XFER_LIMIT, "end of load");
					assert (!loading) else fail_value("loading", 32'(loading), 32'd0);
					check_log(1'b1, BLOCKS);
				end
				CMD_BUS: begin
					kind    = save_kind_t'(fa[2:0]);
					bus_req = 1'b1;
					@(negedge clk_sys);
					bus_req = 1'b0;
					kind    = '0;
					repeat (2) @(negedge clk_sys);
					assert (pending == exp0[0])
						else fail_value("pending", 32'(pending), 32'(exp0[0]));
					assert (led == exp0[0]) else fail_value("led", 32'(led), 32'(exp0[0]));
				end
				CMD_MOUNT: begin
					img_blocks   = fa;
					img_readonly = fb[0];
					img_mounted  = 1'b1;
					@(negedge clk_sys);
					img_mounted = 1'b0;
					repeat (2) @(negedge clk_sys);
				end
				CMD_LOAD: begin
					pulse_request(1'b0);
					if (exp0 == 16'd0) begin
						expect_quiet("load request");
					end else begin
						wait_busy(1'b1, START_LIMIT, "start of load");
						assert (loading) else fail_value("loading", 32'(loading), 32'd1);
						wait_busy(1'b0, XFER_LIMIT, "end of load");
						assert (!loading) else fail_value("loading", 32'(loading), 32'd0);
						check_log(1'b1, BLOCKS);
					end
				end
				CMD_SAVE: begin
					pulse_request(1'b1);
					if (exp0 == 16'd0) begin
						expect_quiet("save request");
					end else begin
						wait_busy(1'b1, START_LIMIT, "start of save");
						assert (!loading) else fail_value("loading", 32'(loading), 32'd0);
						wait_busy(1'b0, XFER_LIMIT, "end of save");
						check_log(1'b0, int'(exp0));
						assert (!pending) else fail_value("pending", 32'(pending), 32'd0);
					end
				end
				default: fail_text("unknown command in the stimulus file");
			endcase
			r++;
			if (r == NREC)
				done = 1'b1; // Ran off the end of the record array
		end
		$display("RESULT: PASS");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
verilog/loader_pkg.sv
verilog/save_pkg.sv
verilog/cart_scanner.sv
verilog/save_size_tracker.sv
verilog/block_sequencer.sv
verilog/backup_controller.sv
verilog/save_top.sv
bench/save_asserts.sv
bench/save_tb.sv

// File: verilog/backup_controller.sv
/* Backup load and save controller */
`default_nettype none

module backup_controller #(
	parameter int LBA_W = 8
) (
	input  wire                       clk_sys,
	input  wire                       arst_n,
	input  wire                       load_req,
	input  wire                       save_req,
	input  wire                       bus_req,
	input  wire save_pkg::save_kind_t kind,
	input  wire                       cart_active,
	input  wire                       cart_end,
	input  wire                       save_ena,
	input  wire [LBA_W-1:0]           save_last,
	input  wire                       sd_ack,
	output logic                      sd_rd,
	output logic                      sd_wr,
	output logic [LBA_W-1:0]          sd_lba,
	output logic                      pending,
	output logic                      busy,
	output logic                      loading,
	output logic                      xfer_start,
	input  wire                       xfer_done
);
	import save_pkg::*;

	xfer_phase_e phase;
	logic        load_q;   // Request levels, one cycle late
	logic        save_q;
	logic        ack_q;
	logic        load_go;
	logic        save_go;
	logic        go;
	logic        go_load;
	logic        ack_fall;
	logic        bus_write;
	logic        late_wr;  // Save memory written during a save
	logic        last_blk;

	assign bus_write = bus_req && (kind.eeprom || kind.sram || kind.flash);
	assign load_go   = load_req && save_ena && !load_q && !cart_active;
	assign save_go   = save_req && save_ena && !save_q && pending && !cart_active;
	assign go_load   = load_go || cart_end; // Every cart download ends in a load
	assign go        = go_load || save_go;
	assign ack_fall  = ack_q && !sd_ack;
	assign busy      = (phase != PH_IDLE);
	assign last_blk  = loading ? &sd_lba : (sd_lba == save_last); // Load reads all

	// ==================================================================
	// Pending flag
	// ==================================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			pending <= 1'b0;
			late_wr <= 1'b0;
		end else if (!busy) begin
			if (go) begin
				pending <= 1'b0;
				late_wr <= (bus_write || late_wr) && !go_load;
			end else begin
				late_wr <= 1'b0;
				if (bus_write || late_wr)
					pending <= 1'b1;
			end
		end else if (bus_write && !loading) begin
			late_wr <= 1'b1; // Picked up once the save is over
		end
	end

	// ==================================================================
	// Transfer FSM
	// ==================================================================
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			phase      <= PH_IDLE;
			sd_rd      <= 1'b0;
			sd_wr      <= 1'b0;
			sd_lba     <= '0;
			loading    <= 1'b0;
			xfer_start <= 1'b0;
			load_q     <= 1'b0;
			save_q     <= 1'b0;
			ack_q      <= 1'b0;
		end else begin
			load_q <= load_req && save_ena;
			save_q <= save_req && save_ena;
			ack_q  <= sd_ack;
			if (!ack_q && sd_ack) begin
				sd_rd <= 1'b0; // Strobe drops on the ack rise
				sd_wr <= 1'b0;
			end
			case (phase)
				PH_IDLE: begin
					xfer_start <= 1'b0;
					sd_lba     <= '0;
					if (go) begin
						phase   <= PH_A;
						loading <= go_load;
					end
				end
				PH_A: begin
					if (loading)
						sd_rd <= 1'b1;      // Load reads the block first
					else
						xfer_start <= 1'b1; // Save drains memory first
					phase <= PH_B;
				end
				PH_B: begin
					if (loading && ack_fall) begin
						xfer_start <= 1'b1; // Fill memory from the device block
						phase      <= PH_C;
					end else if (!loading && xfer_done) begin
						xfer_start <= 1'b0;
						sd_wr      <= 1'b1;
						phase      <= PH_C;
					end
				end
				PH_C: begin
					if (loading ? xfer_done : ack_fall) begin
						xfer_start <= 1'b0;
						sd_lba     <= sd_lba + 1'b1;
						if (last_blk) begin
							phase   <= PH_IDLE;
							loading <= 1'b0;
						end else begin
							phase <= PH_A;
						end
					end
				end
				default: phase <= PH_IDLE;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: verilog/block_sequencer.sv
/* Block word sequencer */
`default_nettype none

module block_sequencer #(
	parameter int BLOCK_AW = 8
) (
	input  wire                           clk_sys,
	input  wire                           arst_n,
	input  wire                           xfer_start,
	input  wire                           write,
	input  wire [save_pkg::MEM_BLK_W-1:0] lba,
	output save_pkg::mem_req_t            mem,
	input  wire                           mem_ack,
	output logic                          xfer_done
);
	import save_pkg::*;

	logic [BLOCK_AW-1:0] word_idx;
	logic                waiting; // Request out, ack not yet seen
	logic                req_q;
	logic                done_q;

	// Two phase loop, issue one request then wait for its ack
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			word_idx <= '0;
			waiting  <= 1'b0;
			req_q    <= 1'b0;
			done_q   <= 1'b0;
		end else begin
			req_q <= 1'b0; // Request is a single cycle pulse
			if (!xfer_start) begin
				word_idx <= '0;   // Idle between blocks
				waiting  <= 1'b0;
				done_q   <= 1'b0;
			end else if (!done_q) begin
				if (!waiting) begin
					req_q   <= 1'b1;
					waiting <= 1'b1;
				end else if (mem_ack) begin
					waiting <= 1'b0;
					if (&word_idx)
						done_q <= 1'b1; // Last word acked
					else
						word_idx <= word_idx + 1'b1;
				end
			end
		end
	end

	// Done drops together with the start level
	assign xfer_done = done_q && xfer_start;

	always_comb begin
		mem.req       = req_q;
		mem.write     = write;
		mem.addr.blk  = lba;
		mem.addr.word = MEM_WORD_W'(word_idx);
	end

endmodule

`default_nettype wire

// File: verilog/cart_scanner.sv
/* Cartridge download scanner */
`default_nettype none

module cart_scanner (
	input  wire                              clk_sys,
	input  wire                              arst_n,
	input  wire loader_pkg::dl_stream_t      dl,
	output logic                             cart_active,
	output logic                             cart_start,
	output logic                             cart_end,
	output logic                             flash_1m,
	output logic [loader_pkg::DL_ADDR_W-1:0] last_addr
);
	import loader_pkg::*;

	localparam logic [71:0] FLASH_SIG = "FLASH1M_V"; // 9 chars

	dl_kind_e    kind;
	logic        cart_q;    // cart_active one cycle late
	logic        cart_rise;
	logic        cart_fall;
	logic [63:0] hist;      // Last 8 bytes, newest in the low byte
	logic [7:0]  lo_byte;
	logic [7:0]  hi_byte;

	// ==================================================================
	// Download kind and edges
	// ==================================================================
	always_comb begin
		if (dl.index == '0)
			kind = DL_BIOS;
		else if (&dl.index)
			kind = DL_CODE;
		else
			kind = DL_CART;
	end

	assign cart_active = dl.download && (kind == DL_CART);
	assign cart_rise   = cart_active && !cart_q;
	assign cart_fall   = cart_q && !cart_active;

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cart_q     <= 1'b0;
			cart_start <= 1'b0;
			cart_end   <= 1'b0;
			last_addr  <= '0;
		end else begin
			cart_q     <= cart_active;
			cart_start <= cart_rise; // Pulses one cycle after the rise
			cart_end   <= cart_fall;
			if (cart_fall)
				last_addr <= dl.addr; // Address still valid on the fall cycle
		end
	end

	// ==================================================================
	// Flash 1M signature search
	// ==================================================================
	assign lo_byte = dl.data[7:0];
	assign hi_byte = dl.data[15:8];

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			hist     <= '0;
			flash_1m <= 1'b0;
		end else begin
			if (cart_start)
				flash_1m <= 1'b0; // New cart, forget the old result
			if (cart_active && dl.wr) begin
				// Signature ending on the low byte, or on the high byte
				if ({hist, lo_byte} == FLASH_SIG)
					flash_1m <= 1'b1;
				if ({hist[55:0], lo_byte, hi_byte} == FLASH_SIG)
					flash_1m <= 1'b1;
				hist <= {(cart_rise ? 48'd0 : hist[47:0]), lo_byte, hi_byte};
			end
		end
	end

endmodule

`default_nettype wire

// File: verilog/loader_pkg.sv
/* Host download stream types */
`default_nettype none

package loader_pkg;

	localparam int DL_ADDR_W  = 27; // Byte address of the download
	localparam int DL_INDEX_W = 8;
	localparam int DL_DATA_W  = 16;

	// One beat of the host download stream
	typedef struct packed {
		logic                  download; // High for the whole transfer
		logic [DL_INDEX_W-1:0] index;    // Selects what is downloaded
		logic [DL_ADDR_W-1:0]  addr;
		logic [DL_DATA_W-1:0]  data;     // Low byte comes first in the file
		logic                  wr;       // One cycle per data word
	} dl_stream_t;

	// Index 0 is bios, all ones is code, anything else a cart
	typedef enum logic [1:0] {
		DL_BIOS,
		DL_CART,
		DL_CODE
	} dl_kind_e;

endpackage

`default_nettype wire

// File: verilog/save_pkg.sv
/* Backup save types */
`default_nettype none

package save_pkg;

	// Save kinds as reported by the core, all levels
	typedef struct packed {
		logic eeprom;
		logic sram;
		logic flash;
	} save_kind_t;

	// Last block index of each kind, in 512 byte blocks
	localparam int SZ_EEPROM       = 15;  // 8 KB
	localparam int SZ_SRAM         = 63;  // 32 KB
	localparam int SZ_FLASH        = 127; // 64 KB
	localparam int SZ_FLASH_1M_BIT = 7;   // 128 KB part adds this bit

	// Memory channel geometry, 256 words of 16 bits per block
	localparam int MEM_BLK_W  = 8;
	localparam int MEM_WORD_W = 8;

	// Per block steps of the load/save FSM
	typedef enum logic [1:0] {
		PH_IDLE,
		PH_A,
		PH_B,
		PH_C
	} xfer_phase_e;

	typedef struct packed {
		logic [MEM_BLK_W-1:0]  blk;
		logic [MEM_WORD_W-1:0] word;
	} mem_addr_t;

	typedef struct packed {
		logic      req;   // One cycle per word
		logic      write; // Write into backup memory (load direction)
		mem_addr_t addr;
	} mem_req_t;

endpackage

`default_nettype wire

// File: verilog/save_size_tracker.sv
/* Save size tracker */
`default_nettype none

module save_size_tracker #(
	parameter int LBA_W = 8
) (
	input  wire                       clk_sys,
	input  wire                       arst_n,
	input  wire                       bus_req,
	input  wire save_pkg::save_kind_t kind,
	input  wire                       cart_start,
	input  wire                       flash_1m,
	input  wire                       img_mounted,
	input  wire                       img_readonly,
	input  wire [LBA_W-1:0]           img_blocks,
	output logic [LBA_W-1:0]          save_last,
	output logic                      save_ena
);
	import save_pkg::*;

	logic             use_img;    // Image size wins until next cart
	logic             img_take;
	logic [LBA_W-1:0] flash_mask;
	logic [LBA_W-1:0] kind_mask;

	// 1M flash doubles the block count
	assign flash_mask = LBA_W'(SZ_FLASH) | (LBA_W'(flash_1m) << SZ_FLASH_1M_BIT);

	// Mask of every kind seen on this access
	always_comb begin
		kind_mask = '0;
		if (kind.eeprom)
			kind_mask = kind_mask | LBA_W'(SZ_EEPROM);
		if (kind.sram)
			kind_mask = kind_mask | LBA_W'(SZ_SRAM);
		if (kind.flash)
			kind_mask = kind_mask | flash_mask;
	end

	// Empty or read only images keep the kind based size
	assign img_take = img_mounted && !img_readonly && (img_blocks != '0);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			use_img   <= 1'b0;
			save_last <= '0;
			save_ena  <= 1'b0;
		end else begin
			if (cart_start) begin
				use_img   <= 1'b0;
				save_last <= '0;
			end else if (img_take) begin
				use_img   <= 1'b1;
				save_last <= img_blocks - 1'b1; // Count to last index
			end else if (bus_req && !use_img) begin
				save_last <= save_last | kind_mask; // Sizes only grow
			end
			save_ena <= |save_last; // One cycle behind the size
		end
	end

endmodule

`default_nettype wire

// File: verilog/save_top.sv
/* Backup save subsystem */
`default_nettype none

module save_top #(
	parameter int BLOCK_AW = 8, // log2 of words per block
	parameter int LBA_W    = 8  // Block counter width
) (
	input  wire                              clk_sys,
	input  wire                              arst_n,
	input  wire loader_pkg::dl_stream_t      dl,
	output logic                             flash_1m,
	output logic [loader_pkg::DL_ADDR_W-1:0] last_addr,
	input  wire                              bus_req,
	input  wire save_pkg::save_kind_t        kind,
	input  wire                              img_mounted,
	input  wire                              img_readonly,
	input  wire [LBA_W-1:0]                  img_blocks,
	input  wire                              load_req,
	input  wire                              save_req,
	input  wire                              sd_ack,
	output logic                             sd_rd,
	output logic                             sd_wr,
	output logic [LBA_W-1:0]                 sd_lba,
	output logic                             pending,
	output logic                             busy,
	output logic                             loading,
	output save_pkg::mem_req_t               mem,
	input  wire                              mem_ack,
	output logic                             led
);
	import save_pkg::*;

	logic             cart_active;
	logic             cart_start;
	logic             cart_end;
	logic [LBA_W-1:0] save_last;
	logic             save_ena;
	logic             xfer_start;
	logic             xfer_done;

	assign led = pending || cart_active; // Lit while unsaved or downloading

	cart_scanner u_scanner (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.dl          (dl),
		.cart_active (cart_active),
		.cart_start  (cart_start),
		.cart_end    (cart_end),
		.flash_1m    (flash_1m),
		.last_addr   (last_addr)
	);

	save_size_tracker #(.LBA_W(LBA_W)) u_size (
		.clk_sys      (clk_sys),
		.arst_n       (arst_n),
		.bus_req      (bus_req),
		.kind         (kind),
		.cart_start   (cart_start),
		.flash_1m     (flash_1m),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_blocks   (img_blocks),
		.save_last    (save_last),
		.save_ena     (save_ena)
	);

	backup_controller #(.LBA_W(LBA_W)) u_ctrl (
		.clk_sys     (clk_sys),
		.arst_n      (arst_n),
		.load_req    (load_req),
		.save_req    (save_req),
		.bus_req     (bus_req),
		.kind        (kind),
		.cart_active (cart_active),
		.cart_end    (cart_end),
		.save_ena    (save_ena),
		.save_last   (save_last),
		.sd_ack      (sd_ack),
		.sd_rd       (sd_rd),
		.sd_wr       (sd_wr),
		.sd_lba      (sd_lba),
		.pending     (pending),
		.busy        (busy),
		.loading     (loading),
		.xfer_start  (xfer_start),
		.xfer_done   (xfer_done)
	);

	block_sequencer #(.BLOCK_AW(BLOCK_AW)) u_seq (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.xfer_start (xfer_start),
		.write      (loading),
		.lba        (MEM_BLK_W'(sd_lba)),
		.mem        (mem),
		.mem_ack    (mem_ack),
		.xfer_done  (xfer_done)
	);

endmodule

`default_nettype wire
